// ==== rtl/fcvt_config.svh ====
`ifndef FCVT_CONFIG_SVH
`define FCVT_CONFIG_SVH

// operand and result word.
`define FCVT_WORD_W 64

// narrow integer target.
`define FCVT_INT32_W 32

// operation code.
`define FCVT_OP_W 3

`define FCVT_MANT_W 53 // hidden bit plus double fraction.
`define FCVT_EXP_W 13  // signed, unbiased.

// unpack, align, round.
`define FCVT_PIPE_DEPTH 3

`endif

// ==== rtl/fp_format_pkg.sv ====
package fp_format_pkg;

  // double precision fields.
  localparam int DBL_EXP_W  = 11;
  localparam int DBL_FRAC_W = 52;
  localparam int DBL_BIAS   = 1023;
  localparam logic [DBL_EXP_W-1:0] DBL_EXP_MAX = '1;

  // single precision fields.
  localparam int SNG_EXP_W  = 8;
  localparam int SNG_FRAC_W = 23;
  localparam int SNG_BIAS   = 127;
  localparam logic [SNG_EXP_W-1:0] SNG_EXP_MAX = '1;

  // one operand word, read as a double or as a pair of singles.
  typedef union packed {
    struct packed {
      logic                  sign;
      logic [DBL_EXP_W-1:0]  exp;
      logic [DBL_FRAC_W-1:0] frac;
    } dbl;
    struct packed {
      struct packed {
        logic                  sign;
        logic [SNG_EXP_W-1:0]  exp;
        logic [SNG_FRAC_W-1:0] frac;
      } hi;
      struct packed {
        logic                  sign;
        logic [SNG_EXP_W-1:0]  exp;
        logic [SNG_FRAC_W-1:0] frac;
      } lo;
    } sng;
  } fp_word_u;

endpackage

// ==== rtl/fcvt_op_pkg.sv ====
`include "fcvt_config.svh"

package fcvt_op_pkg;

  // operation codes.
  localparam logic [`FCVT_OP_W-1:0] OP_CVT_D64  = 3'd0;
  localparam logic [`FCVT_OP_W-1:0] OP_CVT_D32  = 3'd1;
  localparam logic [`FCVT_OP_W-1:0] OP_CVT_S64  = 3'd2;
  localparam logic [`FCVT_OP_W-1:0] OP_CVT_S32  = 3'd3;
  localparam logic [`FCVT_OP_W-1:0] OP_VERBATIM = 3'd4;

  // rounding modes, two bits of the control word.
  localparam int RM_W = 2;
  localparam logic [RM_W-1:0] RM_NEAREST_EVEN = 2'd0;
  localparam logic [RM_W-1:0] RM_TO_ZERO      = 2'd1; // other codes act the same.

  // flag bit positions.
  localparam int FLAG_W       = 2;
  localparam int FLAG_INEXACT = 0;
  localparam int FLAG_INVALID = 1;

endpackage

// ==== rtl/fcvt_unpack.sv ====
`timescale 1ns/10ps
`include "fcvt_config.svh"

module fcvt_unpack (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          stall,
  input  logic                          in_valid,
  input  logic [`FCVT_OP_W-1:0]         op,
  input  logic [fcvt_op_pkg::RM_W-1:0]  rm,
  input  fp_format_pkg::fp_word_u       operand,
  output logic                          up_valid,
  output logic                          up_sign,
  output logic signed [`FCVT_EXP_W-1:0] up_exp,
  output logic [`FCVT_MANT_W-1:0]       up_mant,
  output logic                          up_nan,
  output logic                          up_inf,
  output logic                          up_zero,
  output logic                          up_is32,
  output logic                          up_verbatim,
  output logic [`FCVT_WORD_W-1:0]       up_raw,
  output logic [fcvt_op_pkg::RM_W-1:0]  up_rm
);
  import fp_format_pkg::*;
  import fcvt_op_pkg::*;

  localparam int EXP_W  = `FCVT_EXP_W;
  localparam int MANT_W = `FCVT_MANT_W;

  logic                    is_sng;
  logic                    sign_c;
  logic signed [EXP_W-1:0] exp_c;
  logic [MANT_W-1:0]       mant_c;
  logic                    exp_ones;
  logic                    exp_zero;
  logic                    frac_nz;

  assign is_sng = (op == OP_CVT_S64) || (op == OP_CVT_S32);

  // same word, two readings.
  always_comb begin
    if (is_sng) begin
      sign_c   = operand.sng.lo.sign;
      exp_ones = operand.sng.lo.exp == SNG_EXP_MAX;
      exp_zero = operand.sng.lo.exp == '0;
      frac_nz  = |operand.sng.lo.frac;
      exp_c    = EXP_W'(operand.sng.lo.exp) - EXP_W'(SNG_BIAS);
      // left-justify so both formats share one binary point.
      mant_c   = {1'b1, operand.sng.lo.frac, {(MANT_W-1-SNG_FRAC_W){1'b0}}};
    end else begin
      sign_c   = operand.dbl.sign;
      exp_ones = operand.dbl.exp == DBL_EXP_MAX;
      exp_zero = operand.dbl.exp == '0;
      frac_nz  = |operand.dbl.frac;
      exp_c    = EXP_W'(operand.dbl.exp) - EXP_W'(DBL_BIAS);
      mant_c   = {1'b1, operand.dbl.frac};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      up_valid <= 1'b0;
    end else if (!stall) begin
      up_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      up_sign     <= sign_c;
      up_exp      <= exp_c;
      up_mant     <= mant_c;
      up_nan      <= exp_ones && frac_nz;
      up_inf      <= exp_ones && !frac_nz;
      up_zero     <= exp_zero; // denormals flush here.
      up_is32     <= (op == OP_CVT_D32) || (op == OP_CVT_S32);
      up_verbatim <= op == OP_VERBATIM;
      up_raw      <= operand;
      up_rm       <= rm;
    end
  end

endmodule

// ==== rtl/fcvt_align.sv ====
`timescale 1ns/10ps
`include "fcvt_config.svh"

module fcvt_align (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          stall,
  input  logic                          up_valid,
  input  logic                          up_sign,
  input  logic signed [`FCVT_EXP_W-1:0] up_exp,
  input  logic [`FCVT_MANT_W-1:0]       up_mant,
  input  logic                          up_nan,
  input  logic                          up_inf,
  input  logic                          up_zero,
  input  logic                          up_is32,
  input  logic                          up_verbatim,
  input  logic [`FCVT_WORD_W-1:0]       up_raw,
  input  logic [fcvt_op_pkg::RM_W-1:0]  up_rm,
  output logic                          al_valid,
  output logic                          al_sign,
  output logic [`FCVT_WORD_W-1:0]       al_int,
  output logic                          al_guard,
  output logic                          al_sticky,
  output logic                          al_ovf,
  output logic                          al_nan,
  output logic                          al_inf,
  output logic                          al_zero,
  output logic                          al_is32,
  output logic                          al_verbatim,
  output logic [`FCVT_WORD_W-1:0]       al_raw,
  output logic [fcvt_op_pkg::RM_W-1:0]  al_rm
);
  localparam int WORD_W  = `FCVT_WORD_W;
  localparam int MANT_W  = `FCVT_MANT_W;
  localparam int EXP_W   = `FCVT_EXP_W;
  // exponent -(WORD_W+1) puts the hidden bit at shift zero.
  localparam int SHIFT_OFS = WORD_W + 1;
  localparam int POINT     = SHIFT_OFS + MANT_W - 1; // weight of 2^0.
  localparam int VEC_W     = POINT + WORD_W;

  logic signed [EXP_W-1:0] shamt;
  logic [VEC_W-1:0]        shifted;
  logic [WORD_W-1:0]       int_c;
  logic                    guard_c;
  logic                    sticky_c;
  logic                    ovf_c;

  assign shamt   = up_exp + EXP_W'(SHIFT_OFS);
  assign shifted = VEC_W'(up_mant) << shamt[7:0];

  always_comb begin
    int_c    = '0;
    guard_c  = 1'b0;
    sticky_c = 1'b0;
    ovf_c    = 1'b0;
    if (up_nan || up_inf || up_zero) begin
      // class decides the result later.
    end else if (up_exp >= EXP_W'(WORD_W)) begin
      ovf_c = 1'b1;
    end else if (shamt < 0) begin
      sticky_c = 1'b1; // far below one half.
    end else begin
      int_c    = shifted[VEC_W-1:POINT];
      guard_c  = shifted[POINT-1];
      sticky_c = |shifted[POINT-2:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      al_valid <= 1'b0;
    end else if (!stall) begin
      al_valid <= up_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      al_sign     <= up_sign;
      al_int      <= int_c;
      al_guard    <= guard_c;
      al_sticky   <= sticky_c;
      al_ovf      <= ovf_c;
      al_nan      <= up_nan;
      al_inf      <= up_inf;
      al_zero     <= up_zero;
      al_is32     <= up_is32;
      al_verbatim <= up_verbatim;
      al_raw      <= up_raw;
      al_rm       <= up_rm;
    end
  end

endmodule

// ==== rtl/fcvt_round.sv ====
`timescale 1ns/10ps
`include "fcvt_config.svh"

module fcvt_round (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           stall,
  input  logic                           al_valid,
  input  logic                           al_sign,
  input  logic [`FCVT_WORD_W-1:0]        al_int,
  input  logic                           al_guard,
  input  logic                           al_sticky,
  input  logic                           al_ovf,
  input  logic                           al_nan,
  input  logic                           al_inf,
  input  logic                           al_zero,
  input  logic                           al_is32,
  input  logic                           al_verbatim,
  input  logic [`FCVT_WORD_W-1:0]        al_raw,
  input  logic [fcvt_op_pkg::RM_W-1:0]   al_rm,
  output logic                           res_valid,
  output logic [`FCVT_WORD_W-1:0]        res,
  output logic [fcvt_op_pkg::FLAG_W-1:0] flags
);
  import fcvt_op_pkg::*;

  localparam int WORD_W  = `FCVT_WORD_W;
  localparam int INT32_W = `FCVT_INT32_W;

  localparam logic [WORD_W-1:0] MAX64 = {1'b0, {(WORD_W-1){1'b1}}};
  localparam logic [WORD_W-1:0] MIN64 = {1'b1, {(WORD_W-1){1'b0}}};
  localparam logic [WORD_W-1:0] MAX32 = {{(WORD_W-INT32_W+1){1'b0}}, {(INT32_W-1){1'b1}}};
  localparam logic [WORD_W-1:0] MIN32 = {{(WORD_W-INT32_W+1){1'b1}}, {(INT32_W-1){1'b0}}};

  logic              rnd_up;
  logic [WORD_W:0]   mag;     // one spare bit for the carry.
  logic [WORD_W-1:0] max_t;
  logic [WORD_W-1:0] min_t;
  logic [WORD_W-1:0] neg_lim;
  logic [WORD_W:0]   lim;
  logic              range_err;
  logic              invalid;
  logic [WORD_W-1:0] sgn_val;
  logic [WORD_W-1:0] res_c;
  logic [FLAG_W-1:0] flags_c;

  assign max_t   = al_is32 ? MAX32 : MAX64;
  assign min_t   = al_is32 ? MIN32 : MIN64;
  assign neg_lim = -min_t; // magnitude of the most negative value.

  always_comb begin
    // ties go to the even neighbour.
    rnd_up    = (al_rm == RM_NEAREST_EVEN) && al_guard && (al_sticky || al_int[0]);
    mag       = {1'b0, al_int} + {{WORD_W{1'b0}}, rnd_up};
    lim       = al_sign ? {1'b0, neg_lim} : {1'b0, max_t};
    range_err = al_ovf || al_inf || (mag > lim);
    invalid   = al_nan || range_err;
    sgn_val   = al_sign ? -mag[WORD_W-1:0] : mag[WORD_W-1:0];

    flags_c               = '0;
    flags_c[FLAG_INVALID] = invalid;
    flags_c[FLAG_INEXACT] = (al_guard || al_sticky) && !invalid;

    if (al_verbatim) begin
      res_c   = al_raw;
      flags_c = '0;
    end else if (al_nan) begin
      res_c = max_t;
    end else if (range_err) begin
      res_c = al_sign ? min_t : max_t;
    end else if (al_zero) begin
      res_c = '0;
    end else if (al_is32) begin
      res_c = {{(WORD_W-INT32_W){sgn_val[INT32_W-1]}}, sgn_val[INT32_W-1:0]};
    end else begin
      res_c = sgn_val;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
      res       <= '0;
      flags     <= '0;
    end else if (!stall) begin
      res_valid <= al_valid;
      res       <= res_c;
      flags     <= flags_c;
    end
  end

endmodule

// ==== rtl/fcvt_unit.sv ====
`timescale 1ns/10ps
`include "fcvt_config.svh"

module fcvt_unit (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           in_valid,
  input  logic [`FCVT_OP_W-1:0]          op,
  input  logic [fcvt_op_pkg::RM_W-1:0]   rm,
  input  fp_format_pkg::fp_word_u        operand,
  input  logic                           stall,
  output logic                           res_valid,
  output logic [`FCVT_WORD_W-1:0]        res,
  output logic [fcvt_op_pkg::FLAG_W-1:0] flags
);
  // unpack to align.
  logic                          up_valid;
  logic                          up_sign;
  logic signed [`FCVT_EXP_W-1:0] up_exp;
  logic [`FCVT_MANT_W-1:0]       up_mant;
  logic                          up_nan;
  logic                          up_inf;
  logic                          up_zero;
  logic                          up_is32;
  logic                          up_verbatim;
  logic [`FCVT_WORD_W-1:0]       up_raw;
  logic [fcvt_op_pkg::RM_W-1:0]  up_rm;

  // align to round.
  logic                          al_valid;
  logic                          al_sign;
  logic [`FCVT_WORD_W-1:0]       al_int;
  logic                          al_guard;
  logic                          al_sticky;
  logic                          al_ovf;
  logic                          al_nan;
  logic                          al_inf;
  logic                          al_zero;
  logic                          al_is32;
  logic                          al_verbatim;
  logic [`FCVT_WORD_W-1:0]       al_raw;
  logic [fcvt_op_pkg::RM_W-1:0]  al_rm;

  fcvt_unpack u_unpack (
    .clk, .arst_n, .stall, .in_valid, .op, .rm, .operand,
    .up_valid, .up_sign, .up_exp, .up_mant, .up_nan, .up_inf, .up_zero,
    .up_is32, .up_verbatim, .up_raw, .up_rm
  );

  fcvt_align u_align (
    .clk, .arst_n, .stall,
    .up_valid, .up_sign, .up_exp, .up_mant, .up_nan, .up_inf, .up_zero,
    .up_is32, .up_verbatim, .up_raw, .up_rm,
    .al_valid, .al_sign, .al_int, .al_guard, .al_sticky, .al_ovf, .al_nan,
    .al_inf, .al_zero, .al_is32, .al_verbatim, .al_raw, .al_rm
  );

  fcvt_round u_round (
    .clk, .arst_n, .stall,
    .al_valid, .al_sign, .al_int, .al_guard, .al_sticky, .al_ovf, .al_nan,
    .al_inf, .al_zero, .al_is32, .al_verbatim, .al_raw, .al_rm,
    .res_valid, .res, .flags
  );

endmodule

// ==== tb/fcvt_unit_properties.sv ====
`timescale 1ns/10ps
`include "fcvt_config.svh"

module fcvt_unit_properties (
  input logic                           clk,
  input logic                           arst_n,
  input logic                           stall,
  input logic                           res_valid,
  input logic [`FCVT_WORD_W-1:0]        res,
  input logic [fcvt_op_pkg::FLAG_W-1:0] flags
);
  import fcvt_op_pkg::*;

  int fail_cnt = 0; // assertion failures so far.

  // output stage comes out of reset empty.
  a_reset_clear: assert property (@(posedge clk) $rose(arst_n) |-> !res_valid && res == '0
                                  && flags == '0)
    else begin
      $error("result stage not cleared by reset");
      fail_cnt++;
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
                                 stall |=> $stable(res) && $stable(res_valid))
    else begin
      $error("result changed under stall");
      fail_cnt++;
    end

  a_flags_excl: assert property (@(posedge clk) disable iff (!arst_n)
                                 !(flags[FLAG_INVALID] && flags[FLAG_INEXACT]))
    else begin
      $error("invalid and inexact set together");
      fail_cnt++;
    end

endmodule

bind fcvt_unit fcvt_unit_properties u_props (.*);

// ==== tb/fcvt_unit_tb.sv ====
`timescale 1ns/10ps
`include "fcvt_config.svh"

module fcvt_unit_tb;
  import fcvt_op_pkg::*;

  localparam int N_TESTS      = 20;
  localparam int STALL_BUDGET = 40;
  localparam int TIMEOUT      = 4 * N_TESTS + STALL_BUDGET + 20;

  // short names keep the table rows readable.
  localparam logic [RM_W-1:0]   RNE  = RM_NEAREST_EVEN;
  localparam logic [RM_W-1:0]   RTZ  = RM_TO_ZERO;
  localparam logic [FLAG_W-1:0] NONE = '0;
  localparam logic [FLAG_W-1:0] INX  = FLAG_W'(1) << FLAG_INEXACT;
  localparam logic [FLAG_W-1:0] INV  = FLAG_W'(1) << FLAG_INVALID;

  typedef struct packed {
    logic [`FCVT_OP_W-1:0]   op;
    logic [RM_W-1:0]         rm;
    logic [`FCVT_WORD_W-1:0] operand;
    logic [`FCVT_WORD_W-1:0] res;
    logic [FLAG_W-1:0]       flags;
  } vec_t;

  logic                    clk = 1'b0;
  logic                    arst_n;
  logic                    in_valid;
  logic [`FCVT_OP_W-1:0]   op;
  logic [RM_W-1:0]         rm;
  logic [`FCVT_WORD_W-1:0] operand;
  logic                    stall;
  logic                    res_valid;
  logic [`FCVT_WORD_W-1:0] res;
  logic [FLAG_W-1:0]       flags;

  vec_t vecs [N_TESTS];
  int   idx_q [$]; // rows in flight.
  int   acc_q [$]; // non-stalled edge count at issue.
  int   seed        = 32'h291c_4259;
  int   cycles      = 0;
  int   ns_edges    = 0;
  int   n_pass      = 0;
  int   n_fail      = 0;
  int   cur         = 0;
  int   stalls_used = 0;

  fcvt_unit u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .op        (op),
    .rm        (rm),
    .operand   (operand),
    .stall     (stall),
    .res_valid (res_valid),
    .res       (res),
    .flags     (flags)
  );

  always #50 clk = ~clk;

  task automatic load_table();
    vecs[0]  = '{OP_CVT_D64, RNE, 64'h4008_0000_0000_0000, 64'd3, NONE};
    vecs[1]  = '{OP_CVT_S32, RNE, 64'hdead_beef_c0e0_0000, 64'hffff_ffff_ffff_fff9, NONE};
    vecs[2]  = '{OP_CVT_D64, RNE, 64'h0000_0000_0000_0000, 64'd0, NONE};
    vecs[3]  = '{OP_CVT_S64, RTZ, 64'h7ff8_0000_8000_0000, 64'd0, NONE}; // -0.0 under a NaN.
    vecs[4]  = '{OP_CVT_D64, RNE, 64'h3ff8_0000_0000_0000, 64'd2, INX};
    vecs[5]  = '{OP_CVT_D64, RTZ, 64'h3ff8_0000_0000_0000, 64'd1, INX};
    vecs[6]  = '{OP_CVT_D64, RNE, 64'h4004_0000_0000_0000, 64'd2, INX};
    vecs[7]  = '{OP_CVT_D64, RNE, 64'hc004_0000_0000_0000, 64'hffff_ffff_ffff_fffe, INX};
    vecs[8]  = '{OP_CVT_D64, RTZ, 64'h3fe8_0000_0000_0000, 64'd0, INX};
    vecs[9]  = '{OP_CVT_S64, RNE, 64'h0000_0000_3fc0_0000, 64'd2, INX};
    vecs[10] = '{OP_CVT_D32, RNE, 64'h4629_3e59_39a0_8cea, 64'h0000_0000_7fff_ffff, INV};
    vecs[11] = '{OP_CVT_D64, RNE, 64'hc629_3e59_39a0_8cea, 64'h8000_0000_0000_0000, INV};
    vecs[12] = '{OP_CVT_D64, RNE, 64'h7ff8_0000_0000_0000, 64'h7fff_ffff_ffff_ffff, INV};
    vecs[13] = '{OP_CVT_S32, RNE, 64'h0000_0000_7fc0_0000, 64'h0000_0000_7fff_ffff, INV};
    vecs[14] = '{OP_CVT_S64, RTZ, 64'h0000_0000_7f80_0000, 64'h7fff_ffff_ffff_ffff, INV};
    vecs[15] = '{OP_CVT_D32, RNE, 64'hfff0_0000_0000_0000, 64'hffff_ffff_8000_0000, INV};
    vecs[16] = '{OP_VERBATIM, RNE, 64'h0123_4567_89ab_cdef, 64'h0123_4567_89ab_cdef, NONE};
    vecs[17] = '{OP_CVT_S64, RNE, 64'h1234_5678_42c8_0000, 64'd100, NONE};
    vecs[18] = '{OP_CVT_D32, RTZ, 64'hc0f8_6a00_0000_0000, 64'hffff_ffff_fffe_7960, NONE};
    vecs[19] = '{OP_CVT_D64, 2'd3, 64'h3ff8_0000_0000_0000, 64'd1, INX}; // odd rm code.
  endtask

  task automatic drive_row(input int i);
    in_valid <= 1'b1;
    op       <= vecs[i].op;
    rm       <= vecs[i].rm;
    operand  <= vecs[i].operand;
  endtask

  task automatic pick_stall();
    if (stalls_used < STALL_BUDGET && ($random(seed) & 3) == 0) begin
      stall <= 1'b1;
      stalls_used++;
    end else begin
      stall <= 1'b0;
    end
  endtask

  // called at the edge that replaces the value now on res.
  task automatic check_result();
    int i;
    int lat;
    bit ok;
    ok = 1'b1;
    if (idx_q.size() == 0) begin
      $display("a result came out at %0t with nothing outstanding", $time);
      n_fail++;
      return;
    end
    i   = idx_q.pop_front();
    lat = ns_edges - acc_q.pop_front();
    if (res !== vecs[i].res) begin
      $display("** Error @ %0t: test %0d res %h, expected %h", $time, i, res, vecs[i].res);
      ok = 1'b0;
    end
    if (flags !== vecs[i].flags) begin
      $display("** Error @ %0t: test %0d flags %b, expected %b", $time, i, flags,
               vecs[i].flags);
      ok = 1'b0;
    end
    if (lat != 3) begin // issue edge to retiring edge.
      $display("** Error @ %0t: test %0d latency %0d edges, expected 3", $time, i, lat);
      ok = 1'b0;
    end
    if (ok) begin
      n_pass++;
      $display("test %0d: pass", i);
    end else begin
      n_fail++;
      $display("test %0d: fail", i);
    end
  endtask

  initial begin
    arst_n   = 1'b0;
    in_valid = 1'b0;
    op       = '0;
    rm       = '0;
    operand  = '0;
    stall    = 1'b0;
    load_table();
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    drive_row(0);
    while (n_pass + n_fail < N_TESTS) begin
      @(posedge clk);
      if (!stall) begin
        ns_edges++;
        if (res_valid) begin
          check_result();
        end
        if (in_valid) begin
          idx_q.push_back(cur);
          acc_q.push_back(ns_edges);
          cur++;
          if (cur < N_TESTS) begin
            drive_row(cur);
          end else begin
            in_valid <= 1'b0;
          end
        end
      end
      pick_stall();
    end
    $display("%0d passed, %0d failed, %0d assertion failures", n_pass, n_fail,
             u_dut.u_props.fail_cnt);
    if (n_fail == 0 && u_dut.u_props.fail_cnt == 0 && idx_q.size() == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles with results still missing", cycles);
      $display("tests failed");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/fp_format_pkg.sv
rtl/fcvt_op_pkg.sv
rtl/fcvt_unpack.sv
rtl/fcvt_align.sv
rtl/fcvt_round.sv
rtl/fcvt_unit.sv
tb/fcvt_unit_properties.sv
tb/fcvt_unit_tb.sv

// ==== Bender.yml ====
package:
  name: fcvt_unit

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fp_format_pkg.sv
      - rtl/fcvt_op_pkg.sv
      - rtl/fcvt_unpack.sv
      - rtl/fcvt_align.sv
      - rtl/fcvt_round.sv
      - rtl/fcvt_unit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/fcvt_unit_properties.sv
      - tb/fcvt_unit_tb.sv
